/* design/sys_pkg.sv */
package sys_pkg;

    // physical register file geometry, R10K style with one unified file
    localparam int PHYS_REG_COUNT = 64;
    localparam int TAG_WIDTH = $clog2(PHYS_REG_COUNT);
    localparam int DATA_WIDTH = 32;

    typedef logic [TAG_WIDTH-1:0] phys_tag_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // tag 0 is hardwired to zero in the register file
    localparam phys_tag_t ZERO_TAG = '0;

    // shifts use the low 5 bits of operand b
    // slt compares signed and returns 1 or 0
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    // what the issue logic sends, sources still named by tag
    typedef struct packed {
        alu_op_t   op;
        phys_tag_t dest;
        phys_tag_t src_a;
        phys_tag_t src_b;
    } issue_packet_t;

    // after operand read, both sources carry their values
    typedef struct packed {
        alu_op_t   op;
        phys_tag_t dest;
        data_t     opnd_a;
        data_t     opnd_b;
    } exec_packet_t;

endpackage

/* design/reg_file.sv */
module reg_file import sys_pkg::*; #(
    parameter int NUM_READ_PORTS  = 2,
    parameter int NUM_WRITE_PORTS = 2
) (
    input  logic                             clock,
    input  logic                             reset,

    input  phys_tag_t [NUM_READ_PORTS-1:0]   read_tags,
    output data_t     [NUM_READ_PORTS-1:0]   read_data,

    input  logic      [NUM_WRITE_PORTS-1:0]  write_en,
    input  phys_tag_t [NUM_WRITE_PORTS-1:0]  write_tags,
    input  data_t     [NUM_WRITE_PORTS-1:0]  write_data
);

    // flip-flop storage, one entry per physical register
    data_t [PHYS_REG_COUNT-1:0] regs;
    data_t [PHYS_REG_COUNT-1:0] regs_next;

    // reads see this cycle's writes, with the higher port taking priority
    always_comb begin
        for (int r = 0; r < NUM_READ_PORTS; r++) begin
            read_data[r] = regs[read_tags[r]];
            for (int w = 0; w < NUM_WRITE_PORTS; w++) begin
                if (write_en[w] && write_tags[w] == read_tags[r]) begin
                    read_data[r] = write_data[w];
                end
            end
            // the zero register overrides any forwarding
            if (read_tags[r] == ZERO_TAG) begin
                read_data[r] = '0;
            end
        end
    end

    // later ports are applied last and so win on a shared tag
    always_comb begin
        regs_next = regs;
        for (int w = 0; w < NUM_WRITE_PORTS; w++) begin
            if (write_en[w] && write_tags[w] != ZERO_TAG) begin
                regs_next[write_tags[w]] = write_data[w];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            regs <= '0;
        end else begin
            regs <= regs_next;
        end
    end

    // the load port and the CDB should never disagree on a tag they both write
    for (genvar i = 0; i < NUM_WRITE_PORTS; i++) begin : g_wr_a
        for (genvar j = i + 1; j < NUM_WRITE_PORTS; j++) begin : g_wr_b
            a_write_conflict: assert property (
                @(posedge clock) disable iff (reset)
                !(write_en[i] && write_en[j]
                  && write_tags[i] == write_tags[j]
                  && write_tags[i] != ZERO_TAG
                  && write_data[i] != write_data[j])
            ) else $warning("write ports %0d and %0d collide on tag %0d", i, j, write_tags[i]);
        end
    end

endmodule

/* design/packet_fifo.sv */
module packet_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clock,
    input  logic     reset,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t entries [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    // no fall-through, the head entry is always a stored one
    assign out_payload = entries[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr] <= in_payload;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bound: assert property (
        @(posedge clock) disable iff (reset)
        count <= CNT_W'(DEPTH)
    ) else $error("FIFO count %0d exceeds depth %0d", count, DEPTH);

    a_head_stable: assert property (
        @(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_payload)
    ) else $error("FIFO head changed while stalled");

endmodule

/* design/operand_read.sv */
module operand_read import sys_pkg::*; (
    input  logic            clock,
    input  logic            reset,

    input  logic            in_valid,
    output logic            in_ready,
    input  issue_packet_t   in_packet,

    // register file read ports 0 and 1
    output phys_tag_t [1:0] rf_read_tags,
    input  data_t     [1:0] rf_read_data,

    output logic            out_valid,
    input  logic            out_ready,
    output exec_packet_t    out_packet
);

    logic accept;

    // the waiting packet's sources go straight to the register file,
    // so a write landing this cycle is picked up by forwarding
    assign rf_read_tags[0] = in_packet.src_a;
    assign rf_read_tags[1] = in_packet.src_b;

    // the output register can take a new packet when it is empty or draining
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            out_packet.op     <= in_packet.op;
            out_packet.dest   <= in_packet.dest;
            out_packet.opnd_a <= rf_read_data[0];
            out_packet.opnd_b <= rf_read_data[1];
        end
    end

endmodule

/* design/alu_writeback.sv */
module alu_writeback import sys_pkg::*; (
    input  logic         clock,
    input  logic         reset,

    input  logic         in_valid,
    output logic         in_ready,
    input  exec_packet_t in_packet,

    // completion bus, one result per handshake
    output logic         cdb_valid,
    input  logic         cdb_ready,
    output phys_tag_t    cdb_tag,
    output data_t        cdb_data,

    output logic         rf_write_en,
    output phys_tag_t    rf_write_tag,
    output data_t        rf_write_data
);

    data_t alu_result;
    logic  accept;

    always_comb begin
        alu_result = '0;
        case (in_packet.op)
            ALU_ADD: alu_result = in_packet.opnd_a + in_packet.opnd_b;
            ALU_SUB: alu_result = in_packet.opnd_a - in_packet.opnd_b;
            ALU_AND: alu_result = in_packet.opnd_a & in_packet.opnd_b;
            ALU_OR:  alu_result = in_packet.opnd_a | in_packet.opnd_b;
            ALU_XOR: alu_result = in_packet.opnd_a ^ in_packet.opnd_b;
            ALU_SLL: alu_result = in_packet.opnd_a << in_packet.opnd_b[4:0];
            ALU_SRL: alu_result = in_packet.opnd_a >> in_packet.opnd_b[4:0];
            ALU_SLT: begin
                alu_result = ($signed(in_packet.opnd_a) < $signed(in_packet.opnd_b))
                           ? data_t'(1) : '0;
            end
            default: alu_result = '0;
        endcase
    end

    // the result register refills on the same edge that the CDB takes it
    assign in_ready = !cdb_valid || cdb_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else if (in_ready) begin
            cdb_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            cdb_tag  <= in_packet.dest;
            cdb_data <= alu_result;
        end
    end

    // commit only on the handshake, so a stalled result is written once
    assign rf_write_en   = cdb_valid && cdb_ready;
    assign rf_write_tag  = cdb_tag;
    assign rf_write_data = cdb_data;

    a_cdb_hold: assert property (
        @(posedge clock) disable iff (reset)
        cdb_valid && !cdb_ready |=> $stable(cdb_tag) && $stable(cdb_data)
    ) else $error("CDB payload changed while stalled");

endmodule

/* design/exec_slice.sv */
module exec_slice import sys_pkg::*; #(
    parameter int ISSUE_DEPTH = 4,
    parameter int EXEC_DEPTH  = 2
) (
    input  logic      clock,
    input  logic      reset,

    input  logic      issue_valid,
    output logic      issue_ready,
    input  alu_op_t   issue_op,
    input  phys_tag_t issue_dest,
    input  phys_tag_t issue_src_a,
    input  phys_tag_t issue_src_b,

    // initial register values enter here, on write port 0
    input  logic      load_en,
    input  phys_tag_t load_tag,
    input  data_t     load_data,

    output logic      cdb_valid,
    input  logic      cdb_ready,
    output phys_tag_t cdb_tag,
    output data_t     cdb_data
);

    issue_packet_t   issue_packet;

    logic            iq_valid;
    logic            iq_ready;
    issue_packet_t   iq_packet;

    logic            rd_valid;
    logic            rd_ready;
    exec_packet_t    rd_packet;

    logic            eq_valid;
    logic            eq_ready;
    exec_packet_t    eq_packet;

    phys_tag_t [1:0] rf_read_tags;
    data_t     [1:0] rf_read_data;

    logic            wb_write_en;
    phys_tag_t       wb_write_tag;
    data_t           wb_write_data;

    assign issue_packet = '{op: issue_op, dest: issue_dest,
                            src_a: issue_src_a, src_b: issue_src_b};

    packet_fifo #(
        .payload_t (issue_packet_t),
        .DEPTH     (ISSUE_DEPTH)
    ) issue_fifo (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (issue_valid),
        .in_ready    (issue_ready),
        .in_payload  (issue_packet),
        .out_valid   (iq_valid),
        .out_ready   (iq_ready),
        .out_payload (iq_packet)
    );

    operand_read opr0 (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (iq_valid),
        .in_ready     (iq_ready),
        .in_packet    (iq_packet),
        .rf_read_tags (rf_read_tags),
        .rf_read_data (rf_read_data),
        .out_valid    (rd_valid),
        .out_ready    (rd_ready),
        .out_packet   (rd_packet)
    );

    packet_fifo #(
        .payload_t (exec_packet_t),
        .DEPTH     (EXEC_DEPTH)
    ) exec_fifo (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (rd_valid),
        .in_ready    (rd_ready),
        .in_payload  (rd_packet),
        .out_valid   (eq_valid),
        .out_ready   (eq_ready),
        .out_payload (eq_packet)
    );

    alu_writeback wb0 (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (eq_valid),
        .in_ready      (eq_ready),
        .in_packet     (eq_packet),
        .cdb_valid     (cdb_valid),
        .cdb_ready     (cdb_ready),
        .cdb_tag       (cdb_tag),
        .cdb_data      (cdb_data),
        .rf_write_en   (wb_write_en),
        .rf_write_tag  (wb_write_tag),
        .rf_write_data (wb_write_data)
    );

    // port 1 is the CDB and wins over the load port on a shared tag
    reg_file #(
        .NUM_READ_PORTS  (2),
        .NUM_WRITE_PORTS (2)
    ) rf0 (
        .clock      (clock),
        .reset      (reset),
        .read_tags  (rf_read_tags),
        .read_data  (rf_read_data),
        .write_en   ({wb_write_en, load_en}),
        .write_tags ({wb_write_tag, load_tag}),
        .write_data ({wb_write_data, load_data})
    );

endmodule

/* tests/exec_slice_tb.sv */
module exec_slice_tb import sys_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = 200;
    localparam int RANDOM_ROWS  = 40;
    localparam int IDLE_CYCLES  = 10;

    typedef struct packed {
        alu_op_t   op;
        phys_tag_t dest;
        phys_tag_t src_a;
        phys_tag_t src_b;
        logic      drain;
    } row_t;

    typedef struct packed {
        phys_tag_t tag;
        data_t     data;
    } result_t;

    typedef enum {READY_HIGH, READY_LOW, READY_RANDOM} ready_mode_t;

    logic      clock;
    logic      reset;
    logic      issue_valid;
    logic      issue_ready;
    alu_op_t   issue_op;
    phys_tag_t issue_dest;
    phys_tag_t issue_src_a;
    phys_tag_t issue_src_b;
    logic      load_en;
    phys_tag_t load_tag;
    data_t     load_data;
    logic      cdb_valid;
    logic      cdb_ready;
    phys_tag_t cdb_tag;
    data_t     cdb_data;

    data_t       model [PHYS_REG_COUNT];
    result_t     expected_q [$];
    ready_mode_t ready_mode = READY_HIGH;
    logic [31:0] lfsr_state = 32'hca999ac8;
    logic        ready_dropped = 1'b0;

    // initial register contents, tag 0 included to show that it stays zero
    phys_tag_t load_tags [8] = '{6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7, 6'd8, 6'd0};
    data_t     load_values [8] = '{32'h0000_0005, 32'hffff_fffb, 32'h8000_0000,
                                   32'h0000_0023, 32'h7fff_ffff, 32'h1234_5678,
                                   32'h0000_001f, 32'hdead_beef};

    // op, dest, src a, src b, drain before issue
    row_t rows [13] = '{
        '{ALU_ADD, 6'd1,  6'd0,  6'd0,  1'b0},
        '{ALU_ADD, 6'd10, 6'd6,  6'd2,  1'b0},
        '{ALU_SUB, 6'd11, 6'd2,  6'd3,  1'b0},
        '{ALU_AND, 6'd12, 6'd7,  6'd3,  1'b0},
        '{ALU_OR,  6'd13, 6'd4,  6'd2,  1'b0},
        '{ALU_XOR, 6'd14, 6'd7,  6'd6,  1'b0},
        '{ALU_SLL, 6'd15, 6'd7,  6'd5,  1'b0},
        '{ALU_SRL, 6'd16, 6'd4,  6'd8,  1'b0},
        '{ALU_SLT, 6'd17, 6'd3,  6'd2,  1'b0},
        '{ALU_SLT, 6'd18, 6'd6,  6'd4,  1'b0},
        '{ALU_ADD, 6'd19, 6'd10, 6'd11, 1'b1},
        '{ALU_SUB, 6'd20, 6'd19, 6'd0,  1'b1},
        '{ALU_OR,  6'd21, 6'd0,  6'd0,  1'b0}
    };

    exec_slice dut0 (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_op    (issue_op),
        .issue_dest  (issue_dest),
        .issue_src_a (issue_src_a),
        .issue_src_b (issue_src_b),
        .load_en     (load_en),
        .load_tag    (load_tag),
        .load_data   (load_data),
        .cdb_valid   (cdb_valid),
        .cdb_ready   (cdb_ready),
        .cdb_tag     (cdb_tag),
        .cdb_data    (cdb_data)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("mismatch on %s: got %h, expected %h", name, got, want));
        end
    endtask

    task automatic check_tag(input string name, input phys_tag_t got, input phys_tag_t want);
        if (got !== want) begin
            abort_run($sformatf("mismatch on %s: got %h, expected %h", name, got, want));
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t want);
        if (got !== want) begin
            abort_run($sformatf("mismatch on %s: got %h, expected %h", name, got, want));
        end
    endtask

    // taps 32, 22, 2 and 1
    function automatic logic step_lfsr();
        logic feedback;
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], step_lfsr()};
        end
        return value;
    endfunction

    function automatic void write_model(input phys_tag_t tag, input data_t value);
        if (tag != '0) begin
            model[tag] = value;
        end
    endfunction

    // a result still in flight is the newest value of its tag
    function automatic data_t source_value(input phys_tag_t tag);
        data_t value;
        value = model[tag];
        foreach (expected_q[i]) begin
            if (expected_q[i].tag == tag) begin
                value = expected_q[i].data;
            end
        end
        return (tag == '0) ? '0 : value;
    endfunction

    function automatic data_t expected_result(input alu_op_t op, input data_t a, input data_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a + ~b + 32'd1;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            // differing signs decide by the sign of a alone
            ALU_SLT: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            default: return '0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #1;
        case (ready_mode)
            READY_LOW:    cdb_ready = 1'b0;
            READY_RANDOM: cdb_ready = step_lfsr();
            default:      cdb_ready = 1'b1;
        endcase
    endtask

    task automatic issue_row(input row_t row);
        result_t pending;
        int      waited;
        pending.tag  = row.dest;
        pending.data = expected_result(row.op, source_value(row.src_a), source_value(row.src_b));
        expected_q.push_back(pending);
        issue_valid = 1'b1;
        issue_op    = row.op;
        issue_dest  = row.dest;
        issue_src_a = row.src_a;
        issue_src_b = row.src_b;
        waited = 0;
        while (!issue_ready) begin
            ready_dropped = 1'b1;
            if (waited == WAIT_LIMIT) begin
                abort_run("issue was not accepted within the cycle limit");
            end else begin
                next_cycle();
                waited++;
            end
        end
        next_cycle();
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("outstanding completions did not drain within the cycle limit");
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    task automatic wait_cdb_valid();
        int waited;
        waited = 0;
        while (!cdb_valid) begin
            if (waited == WAIT_LIMIT) begin
                abort_run("the completion bus never became valid");
            end else begin
                next_cycle();
                waited++;
            end
        end
    endtask

    // every handshake on the CDB is checked against the oldest issued row
    always @(posedge clock) begin
        result_t head;
        if (!reset && cdb_valid && cdb_ready) begin
            if (expected_q.size() == 0) begin
                abort_run("a completion arrived with nothing outstanding");
            end else begin
                head = expected_q.pop_front();
                check_tag("cdb_tag", cdb_tag, head.tag);
                check_data("cdb_data", cdb_data, head.data);
                write_model(cdb_tag, cdb_data);
            end
        end
    end

    initial begin
        row_t        row;
        logic [31:0] bits;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_op    = ALU_ADD;
        issue_dest  = '0;
        issue_src_a = '0;
        issue_src_b = '0;
        load_en     = 1'b0;
        load_tag    = '0;
        load_data   = '0;
        cdb_ready   = 1'b1;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) next_cycle();
        reset = 1'b0;
        next_cycle();
        check_flag("issue_ready", issue_ready, 1'b1);
        check_flag("cdb_valid", cdb_valid, 1'b0);

        foreach (load_tags[i]) begin
            load_en   = 1'b1;
            load_tag  = load_tags[i];
            load_data = load_values[i];
            write_model(load_tags[i], load_values[i]);
            next_cycle();
        end
        load_en = 1'b0;

        foreach (rows[i]) begin
            if (rows[i].drain) begin
                wait_drain();
            end
            issue_row(rows[i]);
        end
        wait_drain();

        // independent rows: sources among the loaded tags, results in the upper half
        ready_mode    = READY_RANDOM;
        ready_dropped = 1'b0;
        for (int n = 0; n < RANDOM_ROWS; n++) begin
            bits      = random_bits(3);
            row.op    = alu_op_t'(bits[2:0]);
            bits      = random_bits(5);
            row.dest  = {1'b1, bits[4:0]};
            row.src_a = phys_tag_t'(2 + (random_bits(3) % 7));
            row.src_b = phys_tag_t'(2 + (random_bits(3) % 7));
            row.drain = 1'b0;
            issue_row(row);
        end
        ready_mode = READY_HIGH;
        wait_drain();
        if (!ready_dropped) begin
            abort_run("issue_ready never dropped while the CDB was back-pressured");
        end

        // the producer waits on the CDB while its consumer is read on the commit edge
        ready_mode = READY_LOW;
        row = '{ALU_ADD, 6'd22, 6'd6, 6'd2, 1'b0};
        issue_row(row);
        wait_cdb_valid();
        row = '{ALU_XOR, 6'd23, 6'd22, 6'd7, 1'b0};
        issue_row(row);
        ready_mode = READY_HIGH;
        cdb_ready  = 1'b1;
        wait_drain();

        // with cdb_ready high, a repeated result would show up on the bus here
        repeat (IDLE_CYCLES) next_cycle();
        if (cdb_valid !== 1'b0) begin
            abort_run("the completion bus stayed busy after every issued row completed");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* src.f */
design/sys_pkg.sv
design/reg_file.sv
design/packet_fifo.sv
design/operand_read.sv
design/alu_writeback.sv
design/exec_slice.sv
tests/exec_slice_tb.sv

/* run.sh */
#!/bin/sh
# builds the execute slice and its testbench with Verilator, then runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module exec_slice_tb \
    -Mdir obj_dir \
    -f src.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

if [ ! -x obj_dir/Vexec_slice_tb ]; then
    echo "simulation binary is missing"
    exit 1
fi

./obj_dir/Vexec_slice_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

exit $sim_status
